/* logic/inv_fmt_pkg.sv */
// Signed Q15.16 element format for the matrix inverse datapath
// Products and quotients truncate. There is no rounding or saturation
// Results that overflow DATA_W wrap silently

package inv_fmt_pkg;

  // Element width and binary point
  localparam int DATA_W = 32;
  localparam int FRAC_W = 16;

  typedef logic signed [DATA_W-1:0] elem_t;

  // Dividend of every reciprocal, one in Q.2F
  localparam logic [2*FRAC_W:0] RECIP_NUM = {1'b1, {(2*FRAC_W){1'b0}}};

  // Full product, arithmetic shift back to Q.F, then keep the low word
  function automatic elem_t fx_mul(input elem_t a, input elem_t b);
    logic signed [2*DATA_W-1:0] prod;
    prod = a * b;
    return elem_t'(prod >>> FRAC_W);
  endfunction

endpackage

/* logic/inv_dim_pkg.sv */
// Matrix shape for the inverse engine
// Only order 4 is supported. The index types are sized for it

package inv_dim_pkg;

  // Matrix order and element count
  localparam int MAT_N = 4;
  localparam int ELEMS = MAT_N * MAT_N;

  // Columns of [A | I]
  localparam int AUG_W = 2 * MAT_N;

  typedef logic [1:0] row_t;
  // Augmented column, bit 2 selects the inverse half
  typedef logic [2:0] col_t;
  typedef logic [3:0] cnt_t;

endpackage

/* logic/inv_if.sv */
// Internal buses of the matrix inverse block
// All strobes are single-cycle and have no back-pressure

// Element writes and run start, loader to engine
interface inv_load_if;
  logic                 wr_en;
  inv_dim_pkg::row_t    wr_row;
  inv_dim_pkg::col_t    wr_col;
  inv_fmt_pkg::elem_t   wr_data;
  logic                 go;
  modport loader (output wr_en, wr_row, wr_col, wr_data, go);
  modport engine (input  wr_en, wr_row, wr_col, wr_data, go);
endinterface

// Reciprocal request, quotient holds until the next start
interface inv_div_if;
  logic                 start;
  inv_fmt_pkg::elem_t   divisor;
  logic                 done;
  inv_fmt_pkg::elem_t   quotient;
  modport engine  (output start, divisor, input  done, quotient);
  modport divider (input  start, divisor, output done, quotient);
endinterface

// Run status and combinational readout of the inverse half
interface inv_read_if;
  logic                 fin;
  logic                 err;
  inv_dim_pkg::row_t    rd_row;
  inv_dim_pkg::col_t    rd_col;
  inv_fmt_pkg::elem_t   rd_data;
  modport engine   (output fin, err, rd_data, input  rd_row, rd_col);
  modport streamer (input  fin, err, rd_data, output rd_row, rd_col);
endinterface

/* logic/inv_loader.sv */
// Input side of the inverse block, elements arrive in row-major order
// Strobes while busy is high are dropped without notice
// busy stays high until the readout or the error report is finished

module inv_loader (
  input  logic                CLK,
  input  logic                RST,
  input  logic                in_valid,
  input  inv_fmt_pkg::elem_t  in_data,
  input  logic                load_release,
  output logic                busy,
  inv_load_if.loader          load
);

  import inv_dim_pkg::*;

  // Element number within the matrix
  cnt_t cnt;
  logic accept;
  logic last;

  assign accept = in_valid & ~busy;
  assign last   = (cnt == cnt_t'(ELEMS - 1));

  // Write straight through on the accepting edge
  assign load.wr_en   = accept;
  assign load.wr_row  = row_t'(cnt / MAT_N);
  // Left half only
  assign load.wr_col  = col_t'(cnt % MAT_N);
  assign load.wr_data = in_data;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      cnt     <= '0;
      busy    <= 1'b0;
      load.go <= 1'b0;
    end else begin
      // Start pulse follows the sixteenth write
      load.go <= accept & last;
      if (accept) begin
        // Wraps to zero after the last element
        cnt <= cnt + cnt_t'(1);
      end
      if (accept && last) begin
        busy <= 1'b1;
      end else if (load_release) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

/* logic/inv_recip_div.sv */
// Reciprocal of a Q.16 pivot by restoring division of magnitudes
// Fixed 34 cycles from start to done. A zero divisor is never requested
// Quotient truncates toward zero, then wraps to DATA_W

module inv_recip_div (
  input  logic         CLK,
  input  logic         RST,
  inv_div_if.divider   div
);

  import inv_fmt_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Division state
  //////////////////////////////////////////////////////////////////////

  logic [2*FRAC_W:0]  num;      // dividend bits, MSB shifts out first
  logic [DATA_W-1:0]  rem;
  logic [DATA_W-1:0]  dvs;      // divisor magnitude
  logic [2*FRAC_W:0]  quo;
  logic               neg;
  logic [5:0]         step;
  logic               running;
  logic               last_step;

  // Step operands, from the port on the start cycle
  logic [2*FRAC_W:0]  cur_num;
  logic [DATA_W-1:0]  cur_rem;
  logic [DATA_W-1:0]  cur_dvs;
  logic [DATA_W-1:0]  abs_in;
  logic [DATA_W:0]    trial;
  logic               fits;

  assign abs_in    = div.divisor[DATA_W-1] ? -div.divisor : div.divisor;
  assign cur_num   = div.start ? RECIP_NUM : num;
  assign cur_rem   = div.start ? '0 : rem;
  assign cur_dvs   = div.start ? abs_in : dvs;
  assign trial     = {cur_rem, cur_num[2*FRAC_W]};
  assign fits      = (trial >= {1'b0, cur_dvs});
  // 33 quotient bits done, sign step next
  assign last_step = (step == 6'(2*FRAC_W + 1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running  <= 1'b0;
      step     <= '0;
      div.done <= 1'b0;
    end else begin
      div.done <= 1'b0;
      if (div.start) begin
        running <= 1'b1;
        step    <= 6'd1;
      end else if (running) begin
        if (last_step) begin
          running  <= 1'b0;
          div.done <= 1'b1;
        end else begin
          step <= step + 6'd1;
        end
      end
    end
  end

  // First step runs on the start edge itself
  always_ff @(posedge CLK) begin
    if (div.start || (running && !last_step)) begin
      num <= cur_num << 1;
      rem <= fits ? DATA_W'(trial - {1'b0, cur_dvs}) : DATA_W'(trial);
      // Old bits are all shifted out after 33 steps
      quo <= {quo[2*FRAC_W-1:0], fits};
      dvs <= cur_dvs;
    end
    if (div.start) begin
      neg <= div.divisor[DATA_W-1];
    end
    // Sign step
    if (running && last_step) begin
      div.quotient <= neg ? elem_t'(-quo[DATA_W-1:0]) : elem_t'(quo[DATA_W-1:0]);
    end
  end

endmodule

/* logic/inv_gj_engine.sv */
// Gauss-Jordan elimination on [A | I] without row exchange
// A pivot of exactly zero ends the run with err instead of fin
// One element is updated per cycle. Per column: divide, scale, three eliminations

module inv_gj_engine (
  input  logic          CLK,
  input  logic          RST,
  inv_load_if.engine    load,
  inv_div_if.engine     div,
  inv_read_if.engine    rd
);

  import inv_fmt_pkg::*;
  import inv_dim_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_PIVOT,
    S_DIV,
    S_SCALE,
    S_ELIM
  } state_t;

  state_t state;

  // Augmented matrix, inverse ends up in columns 4 to 7
  elem_t mat [MAT_N][AUG_W];

  // Current pivot, used as both row and column
  row_t  piv;
  col_t  piv_col;
  // Row being eliminated
  row_t  erow;
  row_t  erow_first;
  row_t  erow_next;
  col_t  col;
  elem_t pivot_val;
  elem_t factor;
  elem_t f_use;
  logic  col_end;
  logic  elim_last;

  //////////////////////////////////////////////////////////////////////
  // Index helpers
  //////////////////////////////////////////////////////////////////////

  assign piv_col   = col_t'(piv);
  assign pivot_val = mat[piv][piv_col];
  assign col_end   = (col == col_t'(AUG_W - 1));

  // Factor read live on column 0, before that entry is overwritten
  assign f_use = (col == '0) ? mat[erow][piv_col] : factor;

  // Row walk skips the pivot row
  assign erow_first = (piv == '0) ? row_t'(1) : '0;
  assign erow_next  = (erow + row_t'(1) == piv) ? erow + row_t'(2) : erow + row_t'(1);
  assign elim_last  = (erow == ((piv == row_t'(MAT_N - 1)) ? row_t'(MAT_N - 2)
                                                          : row_t'(MAT_N - 1)));

  // Divider samples this on its start cycle only
  assign div.divisor = pivot_val;

  // Readout of the inverse half
  assign rd.rd_data = mat[rd.rd_row][rd.rd_col];

  //////////////////////////////////////////////////////////////////////
  // Matrix storage and arithmetic
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Loader fills the left half
    if (load.wr_en) begin
      mat[load.wr_row][load.wr_col] <= load.wr_data;
    end
    // Identity in the right half
    if (load.go) begin
      for (int r = 0; r < MAT_N; r++) begin
        for (int c = 0; c < MAT_N; c++) begin
          mat[r][c + MAT_N] <= (r == c) ? elem_t'(1 << FRAC_W) : '0;
        end
      end
    end
    // Pivot row times reciprocal
    if (state == S_SCALE) begin
      mat[piv][col] <= fx_mul(mat[piv][col], div.quotient);
    end
    // Row minus factor times scaled pivot row
    if (state == S_ELIM) begin
      mat[erow][col] <= mat[erow][col] - fx_mul(f_use, mat[piv][col]);
      if (col == '0) begin
        factor <= mat[erow][piv_col];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= S_IDLE;
      piv       <= '0;
      erow      <= '0;
      col       <= '0;
      div.start <= 1'b0;
      rd.fin    <= 1'b0;
      rd.err    <= 1'b0;
    end else begin
      div.start <= 1'b0;
      rd.fin    <= 1'b0;
      rd.err    <= 1'b0;
      case (state)
        S_IDLE: begin
          if (load.go) begin
            piv   <= '0;
            state <= S_PIVOT;
          end
        end
        S_PIVOT: begin
          // Singular for this scheme, abort
          if (pivot_val == '0) begin
            rd.err <= 1'b1;
            state  <= S_IDLE;
          end else begin
            div.start <= 1'b1;
            state     <= S_DIV;
          end
        end
        S_DIV: begin
          if (div.done) begin
            col   <= '0;
            state <= S_SCALE;
          end
        end
        S_SCALE: begin
          col <= col + col_t'(1);
          if (col_end) begin
            erow  <= erow_first;
            state <= S_ELIM;
          end
        end
        S_ELIM: begin
          // Column counter wraps to 0 for the next pass
          col <= col + col_t'(1);
          if (col_end) begin
            if (!elim_last) begin
              erow <= erow_next;
            end else if (piv == row_t'(MAT_N - 1)) begin
              rd.fin <= 1'b1;
              state  <= S_IDLE;
            end else begin
              piv   <= piv + row_t'(1);
              state <= S_PIVOT;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

/* logic/inv_streamer.sv */
// Output side, sends the inverse in row-major order after fin
// Sixteen back-to-back out_valid pulses. The host cannot stall them
// On an engine error only the err strobe is sent

module inv_streamer (
  input  logic                CLK,
  input  logic                RST,
  inv_read_if.streamer        rd,
  output logic                out_valid,
  output inv_fmt_pkg::elem_t  out_data,
  output logic                out_last,
  output logic                err,
  output logic                load_release
);

  import inv_dim_pkg::*;

  // Element address, rests at zero between runs
  cnt_t addr;
  logic active;
  logic fire;
  logic at_end;

  // fin itself sends element 0
  assign fire   = rd.fin | active;
  assign at_end = (addr == cnt_t'(ELEMS - 1));

  // Row and column in the right half
  assign rd.rd_row = row_t'(addr / MAT_N);
  assign rd.rd_col = col_t'(MAT_N) + col_t'(addr % MAT_N);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      addr         <= '0;
      active       <= 1'b0;
      out_valid    <= 1'b0;
      out_last     <= 1'b0;
      err          <= 1'b0;
      load_release <= 1'b0;
    end else begin
      out_valid    <= fire;
      out_last     <= fire & at_end;
      err          <= rd.err;
      // Loader unlocks after the last element or the error
      load_release <= (fire & at_end) | rd.err;
      if (fire) begin
        addr   <= addr + cnt_t'(1);
        active <= ~at_end;
      end
    end
  end

  // Registered output data
  always_ff @(posedge CLK) begin
    if (fire) begin
      out_data <= rd.rd_data;
    end
  end

endmodule

/* logic/matrix_inverse_top.sv */
// 4x4 fixed-point matrix inverse, element stream in and out
// Host must hold off while busy is high. No row pivoting
// Zero pivot gives a single err strobe and no output data

module matrix_inverse_top (
  input  logic                CLK,
  input  logic                RST,
  input  logic                in_valid,
  input  inv_fmt_pkg::elem_t  in_data,
  output logic                out_valid,
  output inv_fmt_pkg::elem_t  out_data,
  output logic                out_last,
  output logic                err,
  output logic                busy
);

  // Streamer tells the loader the run is over
  logic load_release;

  inv_load_if i_load_if ();
  inv_div_if  i_div_if ();
  inv_read_if i_read_if ();

  inv_loader i_loader (
    .CLK         (CLK),
    .RST         (RST),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .load_release(load_release),
    .busy        (busy),
    .load        (i_load_if.loader)
  );

  inv_gj_engine i_engine (
    .CLK (CLK),
    .RST (RST),
    .load(i_load_if.engine),
    .div (i_div_if.engine),
    .rd  (i_read_if.engine)
  );

  inv_recip_div i_div (
    .CLK(CLK),
    .RST(RST),
    .div(i_div_if.divider)
  );

  inv_streamer i_streamer (
    .CLK         (CLK),
    .RST         (RST),
    .rd          (i_read_if.streamer),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_last    (out_last),
    .err         (err),
    .load_release(load_release)
  );

endmodule

/* testbench/tb_inv_model.svh */
// Reference Gauss-Jordan inversion of a 4x4 Q15.16 matrix
// Same operation order as the hardware, no row exchange
// Products and reciprocals truncate, results wrap at 32 bits
`ifndef TB_INV_MODEL_SVH
`define TB_INV_MODEL_SVH

// One matrix in row-major order
typedef inv_fmt_pkg::elem_t elem_arr_t [inv_dim_pkg::ELEMS];

// Q.16 product, keep bits 47 to 16 of the exact result
function automatic inv_fmt_pkg::elem_t ref_mul(input inv_fmt_pkg::elem_t a,
                                               input inv_fmt_pkg::elem_t b);
  logic signed [63:0] wa;
  logic signed [63:0] wb;
  logic signed [63:0] wide;
  wa   = a;
  wb   = b;
  wide = wa * wb;
  return wide[47:16];
endfunction

// 2^32 over the magnitude, sign restored afterwards
function automatic inv_fmt_pkg::elem_t ref_recip(input inv_fmt_pkg::elem_t d);
  logic [63:0]        mag;
  logic [63:0]        q;
  inv_fmt_pkg::elem_t lo;
  mag = {32'd0, d[31] ? -d : d};
  q   = (64'd1 << 32) / mag;
  lo  = q[31:0];
  return d[31] ? -lo : lo;
endfunction

function automatic void inv_ref(input elem_arr_t a, output elem_arr_t inv,
                                output logic singular);
  inv_fmt_pkg::elem_t m [4][8];
  inv_fmt_pkg::elem_t recip;
  inv_fmt_pkg::elem_t f;
  singular = 1'b0;
  // Augmented [A | I]
  for (int r = 0; r < 4; r++) begin
    for (int c = 0; c < 4; c++) begin
      m[r][c]     = a[4*r + c];
      m[r][c + 4] = (r == c) ? 32'sh0001_0000 : 32'sh0;
    end
  end
  for (int k = 0; k < 4 && !singular; k++) begin
    if (m[k][k] == 0) begin
      singular = 1'b1;
    end else begin
      recip = ref_recip(m[k][k]);
      for (int c = 0; c < 8; c++) begin
        m[k][c] = ref_mul(m[k][c], recip);
      end
      // Factor is the entry before its own row is touched
      for (int r = 0; r < 4; r++) begin
        if (r != k) begin
          f = m[r][k];
          for (int c = 0; c < 8; c++) begin
            m[r][c] = m[r][c] - ref_mul(f, m[k][c]);
          end
        end
      end
    end
  end
  for (int i = 0; i < 16; i++) begin
    inv[i] = m[i/4][4 + i%4];
  end
endfunction

`endif

/* testbench/tb_matrix_inverse.sv */
// Testbench for the 4x4 matrix inverse against a reference model
// Covers identity, diagonals, random dominant, singular, busy drop and reset
// Inputs change and outputs are sampled on the falling edge

module tb_matrix_inverse;

  timeunit 1ns;
  timeprecision 1ps;

  import inv_fmt_pkg::*;
  import inv_dim_pkg::*;

  `include "tb_inv_model.svh"

  // Cycle limits for a full run and for busy to fall
  localparam int    RUN_LIMIT  = 2000;
  localparam int    IDLE_LIMIT = 2000;
  localparam elem_t ONE        = 32'sh0001_0000;
  localparam elem_t TWO        = 32'sh0002_0000;
  localparam elem_t FOUR       = 32'sh0004_0000;

  logic  CLK;
  logic  RST;
  logic  in_valid;
  elem_t in_data;
  logic  out_valid;
  elem_t out_data;
  logic  out_last;
  logic  err;
  logic  busy;

  integer    seed = 32'hff18;
  int        errors;
  int        timeouts;
  int        runs_done;
  int        runs_start;
  elem_t     got_q [$];
  elem_arr_t exp_data;
  logic      exp_singular;
  elem_arr_t mat_a;

  matrix_inverse_top i_dut (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (in_valid),
    .in_data  (in_data),
    .out_valid(out_valid),
    .out_data (out_data),
    .out_last (out_last),
    .err      (err),
    .busy     (busy)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_elem(input string name, input elem_t got, input elem_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output collection and checking
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (RST) begin
      got_q.delete();
    end else begin
      if (out_valid) begin
        got_q.push_back(out_data);
        // out_last only with the sixteenth element
        check_flag("out_last", out_last, got_q.size() == ELEMS);
        if (out_last) begin
          check_flag("err expected", 1'b0, exp_singular);
          if (got_q.size() == ELEMS) begin
            for (int i = 0; i < ELEMS; i++) begin
              check_elem($sformatf("out_data[%0d]", i), got_q[i], exp_data[i]);
            end
          end
          got_q.delete();
          runs_done++;
        end
      end
      if (err) begin
        check_flag("err", 1'b1, exp_singular);
        // Only one end strobe per run
        check_flag("repeated end strobe", runs_done != runs_start, 1'b0);
        // No data may precede the error
        check_flag("out_valid before err", got_q.size() != 0, 1'b0);
        got_q.delete();
        runs_done++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic elem_arr_t diag_matrix(input elem_t d0, input elem_t d1,
                                            input elem_t d2, input elem_t d3);
    elem_arr_t a;
    for (int i = 0; i < ELEMS; i++) begin
      a[i] = '0;
    end
    a[0]  = d0;
    a[5]  = d1;
    a[10] = d2;
    a[15] = d3;
    return a;
  endfunction

  task automatic dominant_matrix(output elem_arr_t a, input logic neg_diag);
    elem_t mag;
    for (int i = 0; i < ELEMS; i++) begin
      if (i / MAT_N == i % MAT_N) begin
        // At least 4.0 against three terms below 1.0
        mag  = FOUR + ($random(seed) & 32'h0003_ffff);
        a[i] = (neg_diag && ($random(seed) % 2 != 0)) ? -mag : mag;
      end else begin
        a[i] = $random(seed) % ONE;
      end
    end
  endtask

  // Called on a falling edge with busy low
  task automatic send_matrix(input elem_arr_t a);
    inv_ref(a, exp_data, exp_singular);
    runs_start = runs_done;
    for (int i = 0; i < ELEMS; i++) begin
      in_valid = 1'b1;
      in_data  = a[i];
      @(negedge CLK);
    end
    in_valid = 1'b0;
    check_flag("busy", busy, 1'b1);
  endtask

  // Strobes sent while busy must all be lost
  task automatic drop_strobes(input int count);
    for (int i = 0; i < count; i++) begin
      in_valid = 1'b1;
      in_data  = $random(seed);
      @(negedge CLK);
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_run_end();
    int n;
    n = 0;
    while (runs_done == runs_start && n < RUN_LIMIT) begin
      @(posedge CLK);
      n++;
    end
    if (runs_done == runs_start) begin
      $display("Timeout: no out_last or err within %0d cycles of the load", RUN_LIMIT);
      timeouts++;
    end
  endtask

  // Returns on the falling edge that shows the first out_valid
  task automatic wait_stream();
    int n;
    n = 0;
    while (!out_valid && n < RUN_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    if (!out_valid) begin
      $display("Timeout: no out_valid within %0d cycles of the load", RUN_LIMIT);
      timeouts++;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge CLK);
    while (busy && n < IDLE_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    if (busy) begin
      $display("Timeout: busy stayed high for %0d cycles", IDLE_LIMIT);
      timeouts++;
    end
  endtask

  task automatic run_case(input elem_arr_t a);
    wait_idle();
    send_matrix(a);
    wait_run_end();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    CLK          = 1'b0;
    RST          = 1'b1;
    in_valid     = 1'b0;
    in_data      = '0;
    errors       = 0;
    timeouts     = 0;
    runs_done    = 0;
    runs_start   = 0;
    exp_singular = 1'b0;
    repeat (4) @(negedge CLK);
    RST = 1'b0;

    // Identity and power-of-two diagonals
    run_case(diag_matrix(ONE, ONE, ONE, ONE));
    run_case(diag_matrix(TWO, 32'sh0000_8000, FOUR, 32'sh0000_4000));

    // Random diagonally dominant
    repeat (6) begin
      dominant_matrix(mat_a, 1'b0);
      run_case(mat_a);
    end

    // Negative pivots
    run_case(diag_matrix(-TWO, 32'sh0008_0000, -32'sh0000_8000, ONE));
    repeat (4) begin
      dominant_matrix(mat_a, 1'b1);
      run_case(mat_a);
    end

    // Zero first pivot, then a pivot that cancels to zero
    run_case(diag_matrix('0, ONE, ONE, ONE));
    mat_a = '{ONE, TWO, '0, '0,
              TWO, FOUR, ONE, '0,
              '0, '0, ONE, '0,
              '0, '0, '0, ONE};
    run_case(mat_a);

    // Strobes during a run are dropped
    wait_idle();
    dominant_matrix(mat_a, 1'b0);
    send_matrix(mat_a);
    drop_strobes(5);
    wait_run_end();
    dominant_matrix(mat_a, 1'b1);
    run_case(mat_a);

    // Reset while the inverse streams out
    wait_idle();
    dominant_matrix(mat_a, 1'b0);
    send_matrix(mat_a);
    wait_stream();
    RST = 1'b1;
    @(negedge CLK);
    check_flag("busy", busy, 1'b0);
    check_flag("out_valid", out_valid, 1'b0);
    repeat (3) @(negedge CLK);
    RST = 1'b0;
    dominant_matrix(mat_a, 1'b1);
    run_case(mat_a);

    $display("Runs: %0d, errors: %0d, timeouts: %0d", runs_done, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+testbench
logic/inv_fmt_pkg.sv
logic/inv_dim_pkg.sv
logic/inv_if.sv
logic/inv_loader.sv
logic/inv_recip_div.sv
logic/inv_gj_engine.sv
logic/inv_streamer.sv
logic/matrix_inverse_top.sv
testbench/tb_matrix_inverse.sv

/* Bender.yml */
package:
  name: matrix_inverse

sources:
  - files:
      - logic/inv_fmt_pkg.sv
      - logic/inv_dim_pkg.sv
      - logic/inv_if.sv
      - logic/inv_loader.sv
      - logic/inv_recip_div.sv
      - logic/inv_gj_engine.sv
      - logic/inv_streamer.sv
      - logic/matrix_inverse_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_matrix_inverse.sv
